// File: Bender.yml
package:
  name: executeUnit

sources:
  - rtl/exPkg.sv
  - rtl/exOpIf.sv
  - rtl/exAlu.sv
  - rtl/exBranch.sv
  - rtl/exMemReq.sv
  - rtl/exPipeReg.sv
  - rtl/executeUnit.sv
  - target: test
    files:
      - tb/exChecker.sv
      - tb/tbExecuteUnit.sv

// File: rtl/exAlu.sv
`timescale 1ns/1ps

module exAlu (
    exOpIf.sink                    op,
    output logic [exPkg::xlen-1:0] rdData_o
);

    logic                     isReg;
    logic                     isWord;
    logic                     kBase;
    logic                     kAlt;
    logic [5:0]               shAmt;
    logic [exPkg::xlen-1:0]   opB;
    logic [exPkg::xlen-1:0]   sum;
    logic [exPkg::xlen-1:0]   diff;
    logic [exPkg::xlen-1:0]   sra;
    logic [31:0]              sraW;
    logic [exPkg::xlen-1:0]   immUp;
    logic [exPkg::xlen-1:0]   linkAddr;

    function automatic logic [exPkg::xlen-1:0] sext32(input logic [31:0] v);
        return {{(exPkg::xlen - 32){v[31]}}, v};
    endfunction

    // Register forms take rs2, immediate forms take imm and shamt
    assign isReg = (op.opCode == exPkg::opOp) || (op.opCode == exPkg::opOp32);
    assign isWord = (op.opCode == exPkg::opOpImm32) || (op.opCode == exPkg::opOp32);
    assign opB = isReg ? op.rs2Data : op.imm;
    assign shAmt = isReg ? op.rs2Data[5:0] : op.shamt;

    assign sum = op.rs1Data + opB;
    assign diff = op.rs1Data - opB;
    assign sra = $signed(op.rs1Data) >>> shAmt;
    assign sraW = $signed(op.rs1Data[31:0]) >>> shAmt[4:0];

    // Upper immediate, sign extended from bit 31
    assign immUp = sext32(op.imm[19:0] << 12);
    // Return address for JAL and JALR
    assign linkAddr = {{(exPkg::xlen - exPkg::addrW){1'b0}}, op.instAddr} + 64'd4;

    // funct7 qualifier, base or alt variant
    always_comb begin
        kBase = 1'b1;
        kAlt = 1'b0;
        if (isReg || (isWord && (op.funct3 == 3'b001 || op.funct3 == 3'b101))) begin
            kBase = op.funct7 == exPkg::f7Base;
            kAlt = op.funct7 == exPkg::f7Alt;
        end else if (op.funct3 == 3'b001 || op.funct3 == 3'b101) begin
            // 64-bit shift immediates, funct7[0] is shamt[5]
            kBase = op.funct7[6:1] == exPkg::f7Base[6:1];
            kAlt = op.funct7[6:1] == exPkg::f7Alt[6:1];
        end
    end

    always_comb begin
        rdData_o = '0;
        case (op.opCode)
            exPkg::opOpImm, exPkg::opOp: begin
                case (op.funct3)
                    // ADD/SUB, only register form has SUB
                    3'b000: rdData_o = (isReg && kAlt) ? diff : (kBase ? sum : '0);
                    3'b001: rdData_o = kBase ? op.rs1Data << shAmt : '0;
                    // SLT signed
                    3'b010: rdData_o = kBase ? {63'b0, $signed(op.rs1Data) < $signed(opB)} : '0;
                    // SLTU unsigned
                    3'b011: rdData_o = kBase ? {63'b0, op.rs1Data < opB} : '0;
                    3'b100: rdData_o = kBase ? op.rs1Data ^ opB : '0;
                    // SRL or SRA
                    3'b101: rdData_o = kAlt ? sra : (kBase ? op.rs1Data >> shAmt : '0);
                    3'b110: rdData_o = kBase ? op.rs1Data | opB : '0;
                    default: rdData_o = kBase ? op.rs1Data & opB : '0;
                endcase
            end
            exPkg::opOpImm32, exPkg::opOp32: begin
                // W forms work on the low word
                case (op.funct3)
                    3'b000: rdData_o = (isReg && kAlt) ? sext32(diff[31:0])
                                     : (kBase ? sext32(sum[31:0]) : '0);
                    3'b001: rdData_o = kBase ? sext32(op.rs1Data[31:0] << shAmt[4:0]) : '0;
                    3'b101: rdData_o = kAlt ? sext32(sraW)
                                     : (kBase ? sext32(op.rs1Data[31:0] >> shAmt[4:0]) : '0);
                    default: rdData_o = '0;
                endcase
            end
            exPkg::opLui: rdData_o = immUp;
            exPkg::opAuipc: rdData_o = {{(exPkg::xlen - exPkg::addrW){1'b0}}, op.instAddr}
                                      + (op.imm << 12);
            exPkg::opJal, exPkg::opJalr: rdData_o = linkAddr;
            default: rdData_o = '0;
        endcase
    end

    // Clean operands from decode give a clean result
    resultKnown: assert property (
        @(posedge op.clk_i) disable iff (!op.rstN_i)
        op.valid |-> !$isunknown(rdData_o)
    ) else $error("exAlu result unknown on a valid instruction");

endmodule

// File: rtl/exBranch.sv
`timescale 1ns/1ps

module exBranch (
    exOpIf.sink                op,
    output exPkg::jumpPayloadT jump_o
);

    logic [exPkg::xlen-1:0] jalrSum;
    logic                   taken;
    logic                   lt;
    logic                   ltu;

    assign jalrSum = op.rs1Data + op.imm;
    assign lt = $signed(op.rs1Data) < $signed(op.rs2Data);
    assign ltu = op.rs1Data < op.rs2Data;

    always_comb begin
        jump_o = '0;
        taken = 1'b0;
        case (op.opCode)
            exPkg::opJal: begin
                taken = 1'b1;
                jump_o.jumpAddr = op.instAddr + op.imm[exPkg::addrW-1:0];
            end
            exPkg::opJalr: begin
                taken = 1'b1;
                jump_o.jumpAddr = {jalrSum[exPkg::addrW-1:1], 1'b0};
            end
            exPkg::opBranch: begin
                // Target is formed even when not taken
                jump_o.jumpAddr = op.instAddr + op.imm[exPkg::addrW-1:0];
                case (op.funct3)
                    exPkg::f3Beq: taken = op.rs1Data == op.rs2Data;
                    exPkg::f3Bne: taken = op.rs1Data != op.rs2Data;
                    exPkg::f3Blt: taken = lt;
                    exPkg::f3Bge: taken = !lt;
                    exPkg::f3Bltu: taken = ltu;
                    exPkg::f3Bgeu: taken = !ltu;
                    default: taken = 1'b0;
                endcase
            end
            default: taken = 1'b0;
        endcase
        jump_o.jumpFlag = op.valid && taken;
    end

endmodule

// File: rtl/exMemReq.sv
`timescale 1ns/1ps

module exMemReq (
    exOpIf.sink               op,
    output exPkg::memPayloadT mem_o
);

    logic [exPkg::xlen-1:0] effAddr;

    // Base plus offset, shared by loads and stores
    assign effAddr = op.rs1Data + op.imm;

    always_comb begin
        mem_o = '0;
        case (op.opCode)
            exPkg::opLoad: begin
                mem_o.readAddr = effAddr[exPkg::addrW-1:0];
                // Width and sign handled by the LSU
                mem_o.funct3 = op.funct3;
            end
            exPkg::opStore: begin
                mem_o.writeAddr = effAddr[exPkg::addrW-1:0];
                mem_o.writeData = op.rs2Data;
                case (op.funct3)
                    exPkg::f3Sb: mem_o.writeMask = 4'b0001;
                    exPkg::f3Sh: mem_o.writeMask = 4'b0010;
                    exPkg::f3Sw: mem_o.writeMask = 4'b0100;
                    exPkg::f3Sd: mem_o.writeMask = 4'b1000;
                    // Illegal store width, no size
                    default: mem_o.writeMask = '0;
                endcase
            end
            default: mem_o = '0;
        endcase
    end

    // One opcode per cycle, never a read and a write together
    noReadWrite: assert property (
        @(posedge op.clk_i) disable iff (!op.rstN_i)
        !((|mem_o.readAddr || |mem_o.funct3) && (|mem_o.writeAddr || |mem_o.writeMask))
    ) else $error("exMemReq raised read and write requests together");

endmodule

// File: rtl/exOpIf.sv
`timescale 1ns/1ps

interface exOpIf (
    input logic clk_i,
    input logic rstN_i
);

    // Decoded operation
    logic [exPkg::opW-1:0]    opCode;
    logic [exPkg::f3W-1:0]    funct3;
    logic [exPkg::f7W-1:0]    funct7;
    logic [exPkg::shamtW-1:0] shamt;
    // Operands
    logic [exPkg::xlen-1:0]   imm;
    logic [exPkg::xlen-1:0]   rs1Data;
    logic [exPkg::xlen-1:0]   rs2Data;
    logic [exPkg::addrW-1:0]  instAddr;
    logic                     valid;

    // Top level fills the bundle
    modport source (
        output opCode, funct3, funct7, shamt, imm, rs1Data, rs2Data, instAddr, valid
    );

    // Compute units only read, clock and reset go to their checks
    modport sink (
        input clk_i, rstN_i,
        input opCode, funct3, funct7, shamt, imm, rs1Data, rs2Data, instAddr, valid
    );

endinterface

// File: rtl/exPipeReg.sv
`timescale 1ns/1ps

module exPipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk_i,
    input  logic    rstN_i,
    input  logic    en_i,
    input  payloadT d_i,
    output payloadT q_o
);

    // Capture when downstream is ready, hold otherwise
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            q_o <= '0;
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

    // A stalled edge leaves the stage untouched
    holdStable: assert property (
        @(posedge clk_i) disable iff (!rstN_i)
        !en_i |=> $stable(q_o)
    ) else $error("exPipeReg output moved during a stall");

endmodule

// File: rtl/exPkg.sv
package exPkg;

    // Datapath widths
    localparam int xlen = 64;
    localparam int addrW = 32;
    localparam int regAddrW = 5;
    localparam int pidW = 2;
    localparam int shamtW = 6;
    localparam int opW = 7;
    localparam int f3W = 3;
    localparam int f7W = 7;
    localparam int sizeW = 4;

    // Major opcodes handled by way 0
    localparam logic [opW-1:0] opOpImm = 7'b0010011;
    localparam logic [opW-1:0] opOp = 7'b0110011;
    localparam logic [opW-1:0] opOpImm32 = 7'b0011011;
    localparam logic [opW-1:0] opOp32 = 7'b0111011;
    localparam logic [opW-1:0] opLui = 7'b0110111;
    localparam logic [opW-1:0] opAuipc = 7'b0010111;
    localparam logic [opW-1:0] opJal = 7'b1101111;
    localparam logic [opW-1:0] opJalr = 7'b1100111;
    localparam logic [opW-1:0] opBranch = 7'b1100011;
    localparam logic [opW-1:0] opLoad = 7'b0000011;
    localparam logic [opW-1:0] opStore = 7'b0100011;

    // funct7, alt marks SUB and SRA
    localparam logic [f7W-1:0] f7Base = 7'b0000000;
    localparam logic [f7W-1:0] f7Alt = 7'b0100000;

    // Store widths
    localparam logic [f3W-1:0] f3Sb = 3'b000;
    localparam logic [f3W-1:0] f3Sh = 3'b001;
    localparam logic [f3W-1:0] f3Sw = 3'b010;
    localparam logic [f3W-1:0] f3Sd = 3'b011;

    // Branch conditions
    localparam logic [f3W-1:0] f3Beq = 3'b000;
    localparam logic [f3W-1:0] f3Bne = 3'b001;
    localparam logic [f3W-1:0] f3Blt = 3'b100;
    localparam logic [f3W-1:0] f3Bge = 3'b101;
    localparam logic [f3W-1:0] f3Bltu = 3'b110;
    localparam logic [f3W-1:0] f3Bgeu = 3'b111;

    // One-hot store size, bit 0 byte up to bit 3 doubleword
    typedef logic [sizeW-1:0] sizeCodeT;

    // Writeback side, valid rides along with the rd tags
    typedef struct packed {
        logic                valid;
        logic                rdWriteEnable;
        logic [regAddrW-1:0] rdAddr;
        logic [xlen-1:0]     rdData;
        logic [pidW-1:0]     pId;
    } wbPayloadT;

    // Request to the load/store unit
    typedef struct packed {
        logic [addrW-1:0] readAddr;
        logic [addrW-1:0] writeAddr;
        logic [xlen-1:0]  writeData;
        sizeCodeT         writeMask;
        logic [f3W-1:0]   funct3;
    } memPayloadT;

    // Redirect to the PC unit
    typedef struct packed {
        logic             jumpFlag;
        logic [addrW-1:0] jumpAddr;
    } jumpPayloadT;

endpackage

// File: rtl/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
    input  logic                        clk_i,
    input  logic                        rstN_i,
    input  logic                        rdWriteEnable_i,
    input  logic [exPkg::regAddrW-1:0]  rdAddr_i,
    input  logic [exPkg::addrW-1:0]     instAddr_i,
    input  logic [exPkg::xlen-1:0]      rs1ReadData_i,
    input  logic [exPkg::xlen-1:0]      rs2ReadData_i,
    input  logic [exPkg::xlen-1:0]      imm_i,
    input  logic [exPkg::opW-1:0]       opCode_i,
    input  logic [exPkg::f3W-1:0]       funct3_i,
    input  logic [exPkg::f7W-1:0]       funct7_i,
    input  logic [exPkg::shamtW-1:0]    shamt_i,
    input  logic                        valid_i,
    input  logic                        ready_i,
    input  logic [exPkg::pidW-1:0]      way0PId_i,
    // Writeback side
    output logic                        rdWriteEnable_o,
    output logic [exPkg::regAddrW-1:0]  rdAddr_o,
    output logic [exPkg::xlen-1:0]      rdData_o,
    output logic                        valid_o,
    output logic                        ready_o,
    output logic [exPkg::pidW-1:0]      way0PId_o,
    // Load/store unit
    output logic [exPkg::f3W-1:0]       funct3_o,
    output logic [exPkg::addrW-1:0]     readAddr_o,
    output logic [exPkg::addrW-1:0]     writeAddr_o,
    output logic [exPkg::xlen-1:0]      writeData_o,
    output logic [exPkg::sizeW-1:0]     writeMask_o,
    // PC unit
    output logic                        jumpFlag_o,
    output logic [exPkg::addrW-1:0]     jumpAddr_o
);

    exPkg::wbPayloadT   wbD;
    exPkg::wbPayloadT   wbQ;
    exPkg::memPayloadT  memD;
    exPkg::memPayloadT  memQ;
    exPkg::jumpPayloadT jumpD;
    exPkg::jumpPayloadT jumpQ;
    logic [exPkg::xlen-1:0] aluData;

    exOpIf opIf (.clk_i(clk_i), .rstN_i(rstN_i));

    // Operation bundle from the issue ports
    assign opIf.opCode = opCode_i;
    assign opIf.funct3 = funct3_i;
    assign opIf.funct7 = funct7_i;
    assign opIf.shamt = shamt_i;
    assign opIf.imm = imm_i;
    assign opIf.rs1Data = rs1ReadData_i;
    assign opIf.rs2Data = rs2ReadData_i;
    assign opIf.instAddr = instAddr_i;
    assign opIf.valid = valid_i;

    exAlu u_alu (.op(opIf), .rdData_o(aluData));
    exBranch u_branch (.op(opIf), .jump_o(jumpD));
    exMemReq u_memReq (.op(opIf), .mem_o(memD));

    // Tags travel with the result
    assign wbD = '{valid: valid_i, rdWriteEnable: rdWriteEnable_i, rdAddr: rdAddr_i,
                   rdData: aluData, pId: way0PId_i};

    // Single output stage, stalls with downstream
    exPipeReg #(.payloadT(exPkg::wbPayloadT)) u_wbReg (
        .clk_i(clk_i), .rstN_i(rstN_i), .en_i(ready_i), .d_i(wbD), .q_o(wbQ)
    );
    exPipeReg #(.payloadT(exPkg::memPayloadT)) u_memReg (
        .clk_i(clk_i), .rstN_i(rstN_i), .en_i(ready_i), .d_i(memD), .q_o(memQ)
    );
    exPipeReg #(.payloadT(exPkg::jumpPayloadT)) u_jumpReg (
        .clk_i(clk_i), .rstN_i(rstN_i), .en_i(ready_i), .d_i(jumpD), .q_o(jumpQ)
    );

    // Backpressure passes straight up
    assign ready_o = ready_i;

    assign valid_o = wbQ.valid;
    assign rdWriteEnable_o = wbQ.rdWriteEnable;
    assign rdAddr_o = wbQ.rdAddr;
    assign rdData_o = wbQ.rdData;
    assign way0PId_o = wbQ.pId;
    assign funct3_o = memQ.funct3;
    assign readAddr_o = memQ.readAddr;
    assign writeAddr_o = memQ.writeAddr;
    assign writeData_o = memQ.writeData;
    assign writeMask_o = memQ.writeMask;
    assign jumpFlag_o = jumpQ.jumpFlag;
    assign jumpAddr_o = jumpQ.jumpAddr;

endmodule

// File: tb.f
rtl/exPkg.sv
rtl/exOpIf.sv
rtl/exAlu.sv
rtl/exBranch.sv
rtl/exMemReq.sv
rtl/exPipeReg.sv
rtl/executeUnit.sv
tb/exChecker.sv
tb/tbExecuteUnit.sv

// File: tb/exChecker.sv
`timescale 1ns/1ps

module exChecker (
    input logic                       clk_i,
    input logic                       rstN_i,
    input logic                       rdWriteEnable_i,
    input logic [exPkg::regAddrW-1:0] rdAddr_i,
    input logic [exPkg::addrW-1:0]    instAddr_i,
    input logic [exPkg::xlen-1:0]     rs1ReadData_i,
    input logic [exPkg::xlen-1:0]     rs2ReadData_i,
    input logic [exPkg::xlen-1:0]     imm_i,
    input logic [exPkg::opW-1:0]      opCode_i,
    input logic [exPkg::f3W-1:0]      funct3_i,
    input logic [exPkg::f7W-1:0]      funct7_i,
    input logic [exPkg::shamtW-1:0]   shamt_i,
    input logic                       valid_i,
    input logic                       ready_i,
    input logic [exPkg::pidW-1:0]     way0PId_i,
    // Observed DUT outputs
    input exPkg::wbPayloadT           gotWb_i,
    input exPkg::memPayloadT          gotMem_i,
    input exPkg::jumpPayloadT         gotJump_i,
    input logic                       gotReady_i
);

    typedef struct packed {
        exPkg::wbPayloadT   wb;
        exPkg::memPayloadT  mem;
        exPkg::jumpPayloadT jump;
    } expT;

    expT   expQ[$];
    string tagQ[$];
    expT   expCur;
    expT   expNew;
    string tagCur;
    logic  haveExp = 1'b0;
    logic  popped;
    int    capCount = 0;
    int    cmpCount = 0;
    int    checkCount = 0;
    int    errorCount = 0;

    // Integer result straight from the RV64I rules
    function automatic logic [63:0] aluModel();
        logic        regForm;
        logic        alt;
        logic        legal;
        logic [63:0] a;
        logic [63:0] b;
        logic [5:0]  sh;
        logic [31:0] w;
        logic [63:0] r;
        regForm = (opCode_i == exPkg::opOp) || (opCode_i == exPkg::opOp32);
        a = rs1ReadData_i;
        b = regForm ? rs2ReadData_i : imm_i;
        sh = regForm ? rs2ReadData_i[5:0] : shamt_i;
        alt = funct7_i == exPkg::f7Alt;
        legal = 1'b1;
        r = '0;
        case (opCode_i)
            exPkg::opOp, exPkg::opOpImm: begin
                if (regForm) begin
                    legal = funct7_i == exPkg::f7Base
                            || (alt && (funct3_i == 3'd0 || funct3_i == 3'd5));
                end else if (funct3_i == 3'd1 || funct3_i == 3'd5) begin
                    // funct7 bit 0 doubles as shamt[5]
                    alt = funct3_i == 3'd5 && funct7_i[6:1] == 6'b010000;
                    legal = funct7_i[6:1] == 6'b000000 || alt;
                end else begin
                    alt = 1'b0;
                end
                case (funct3_i)
                    3'd0: r = alt ? a - b : a + b;
                    3'd1: r = a << sh;
                    3'd2: r = {63'd0, $signed(a) < $signed(b)};
                    3'd3: r = {63'd0, a < b};
                    3'd4: r = a ^ b;
                    3'd5: begin
                        if (alt) r = $signed(a) >>> sh;
                        else r = a >> sh;
                    end
                    3'd6: r = a | b;
                    default: r = a & b;
                endcase
                if (!legal) r = '0;
            end
            exPkg::opOp32, exPkg::opOpImm32: begin
                // ADDIW ignores funct7
                case (funct3_i)
                    3'd0: legal = !regForm || funct7_i == exPkg::f7Base || alt;
                    3'd1: legal = funct7_i == exPkg::f7Base;
                    3'd5: legal = funct7_i == exPkg::f7Base || alt;
                    default: legal = 1'b0;
                endcase
                if (funct3_i == 3'd0) w = (regForm && alt) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                else if (funct3_i == 3'd1) w = a[31:0] << sh[4:0];
                else if (alt) w = $signed(a[31:0]) >>> sh[4:0];
                else w = a[31:0] >> sh[4:0];
                r = legal ? {{32{w[31]}}, w} : '0;
            end
            exPkg::opLui: r = {{32{imm_i[19]}}, imm_i[19:0], 12'd0};
            exPkg::opAuipc: r = {32'd0, instAddr_i} + (imm_i << 12);
            // Link value
            exPkg::opJal, exPkg::opJalr: r = {32'd0, instAddr_i} + 64'd4;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic exPkg::jumpPayloadT jumpModel();
        exPkg::jumpPayloadT j;
        logic [63:0]        t;
        logic               cond;
        logic               taken;
        j = '0;
        // funct3[2:1] picks the compare and funct3[0] inverts it
        case (funct3_i[2:1])
            2'b00: cond = rs1ReadData_i == rs2ReadData_i;
            2'b10: cond = $signed(rs1ReadData_i) < $signed(rs2ReadData_i);
            2'b11: cond = rs1ReadData_i < rs2ReadData_i;
            default: cond = 1'b0;
        endcase
        taken = (opCode_i == exPkg::opJal) || (opCode_i == exPkg::opJalr);
        if (opCode_i == exPkg::opBranch && funct3_i[2:1] != 2'b01) begin
            taken = cond ^ funct3_i[0];
        end
        t = rs1ReadData_i + imm_i;
        if (opCode_i == exPkg::opJalr) begin
            j.jumpAddr = t[31:0] & ~32'd1;
        end else if (opCode_i == exPkg::opJal || opCode_i == exPkg::opBranch) begin
            // Branch target exists even when not taken
            j.jumpAddr = instAddr_i + imm_i[31:0];
        end
        j.jumpFlag = valid_i && taken;
        return j;
    endfunction

    function automatic exPkg::memPayloadT memModel();
        exPkg::memPayloadT m;
        logic [63:0]       ea;
        m = '0;
        ea = rs1ReadData_i + imm_i;
        if (opCode_i == exPkg::opLoad) begin
            m.readAddr = ea[31:0];
            m.funct3 = funct3_i;
        end else if (opCode_i == exPkg::opStore) begin
            m.writeAddr = ea[31:0];
            m.writeData = rs2ReadData_i;
            // One-hot size from byte to doubleword
            if (!funct3_i[2]) m.writeMask = 4'b0001 << funct3_i[1:0];
        end
        return m;
    endfunction

    function automatic string opTag();
        case (opCode_i)
            exPkg::opOp, exPkg::opOpImm: return "alu";
            exPkg::opOp32, exPkg::opOpImm32: return "wform";
            exPkg::opLui, exPkg::opAuipc: return "upper";
            exPkg::opJal, exPkg::opJalr: return "jump";
            exPkg::opBranch: return "branch";
            exPkg::opLoad: return "load";
            exPkg::opStore: return "store";
            default: return "unlisted";
        endcase
    endfunction

    task automatic checkField(input string name, input logic [63:0] expVal,
                              input logic [63:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("FAILED %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
        end
    endtask

    // Inputs have settled since the last drive
    always @(posedge clk_i) begin
        if (!rstN_i) begin
            // Reset clears every stage register
            expQ.push_back('0);
            tagQ.push_back("reset");
            capCount++;
        end else if (ready_i) begin
            expNew.wb = '{valid: valid_i, rdWriteEnable: rdWriteEnable_i, rdAddr: rdAddr_i,
                          rdData: aluModel(), pId: way0PId_i};
            expNew.mem = memModel();
            expNew.jump = jumpModel();
            expQ.push_back(expNew);
            tagQ.push_back(opTag());
            capCount++;
        end
    end

    // Compare mid-cycle
    // No new capture means the outputs hold
    always @(negedge clk_i) begin
        popped = 1'b0;
        if (expQ.size() > 0) begin
            expCur = expQ.pop_front();
            tagCur = tagQ.pop_front();
            haveExp = 1'b1;
            popped = 1'b1;
        end else begin
            tagCur = "stall";
        end
        if (haveExp) begin
            checkField({tagCur, " valid_o"}, expCur.wb.valid, gotWb_i.valid);
            checkField({tagCur, " rdWriteEnable_o"}, expCur.wb.rdWriteEnable,
                       gotWb_i.rdWriteEnable);
            checkField({tagCur, " rdAddr_o"}, expCur.wb.rdAddr, gotWb_i.rdAddr);
            checkField({tagCur, " rdData_o"}, expCur.wb.rdData, gotWb_i.rdData);
            checkField({tagCur, " way0PId_o"}, expCur.wb.pId, gotWb_i.pId);
            checkField({tagCur, " readAddr_o"}, expCur.mem.readAddr, gotMem_i.readAddr);
            checkField({tagCur, " writeAddr_o"}, expCur.mem.writeAddr, gotMem_i.writeAddr);
            checkField({tagCur, " writeData_o"}, expCur.mem.writeData, gotMem_i.writeData);
            checkField({tagCur, " writeMask_o"}, expCur.mem.writeMask, gotMem_i.writeMask);
            checkField({tagCur, " funct3_o"}, expCur.mem.funct3, gotMem_i.funct3);
            checkField({tagCur, " jumpFlag_o"}, expCur.jump.jumpFlag, gotJump_i.jumpFlag);
            checkField({tagCur, " jumpAddr_o"}, expCur.jump.jumpAddr, gotJump_i.jumpAddr);
        end
        // Backpressure is a plain wire
        checkField("ready_o", ready_i, gotReady_i);
        if (popped) cmpCount++;
    end

endmodule

// File: tb/tbExecuteUnit.sv
`timescale 1ns/1ps

module tbExecuteUnit;

    localparam int numCaptures = 4000;
    localparam int runLimit = numCaptures * 8;
    localparam int drainLimit = 8;
    // Right-shift Galois form of x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] lfsrTaps = 32'h8020_0003;

    logic                       clk = 1'b0;
    logic                       rstN_i;
    logic                       rdWriteEnable_i;
    logic [exPkg::regAddrW-1:0] rdAddr_i;
    logic [exPkg::addrW-1:0]    instAddr_i;
    logic [exPkg::xlen-1:0]     rs1ReadData_i;
    logic [exPkg::xlen-1:0]     rs2ReadData_i;
    logic [exPkg::xlen-1:0]     imm_i;
    logic [exPkg::opW-1:0]      opCode_i;
    logic [exPkg::f3W-1:0]      funct3_i;
    logic [exPkg::f7W-1:0]      funct7_i;
    logic [exPkg::shamtW-1:0]   shamt_i;
    logic                       valid_i;
    logic                       ready_i;
    logic [exPkg::pidW-1:0]     way0PId_i;
    logic                       rdWriteEnable_o;
    logic [exPkg::regAddrW-1:0] rdAddr_o;
    logic [exPkg::xlen-1:0]     rdData_o;
    logic                       valid_o;
    logic                       ready_o;
    logic [exPkg::pidW-1:0]     way0PId_o;
    logic [exPkg::f3W-1:0]      funct3_o;
    logic [exPkg::addrW-1:0]    readAddr_o;
    logic [exPkg::addrW-1:0]    writeAddr_o;
    logic [exPkg::xlen-1:0]     writeData_o;
    logic [exPkg::sizeW-1:0]    writeMask_o;
    logic                       jumpFlag_o;
    logic [exPkg::addrW-1:0]    jumpAddr_o;
    logic [31:0]                lfsr;
    int                         captures;
    int                         cycles;
    int                         timeouts;

    always #2 clk = ~clk;

    executeUnit u_dut (.clk_i(clk), .*);

    // Outputs regrouped in payload field order
    exChecker u_chk (
        .clk_i(clk),
        .gotWb_i({valid_o, rdWriteEnable_o, rdAddr_o, rdData_o, way0PId_o}),
        .gotMem_i({readAddr_o, writeAddr_o, writeData_o, writeMask_o, funct3_o}),
        .gotJump_i({jumpFlag_o, jumpAddr_o}),
        .gotReady_i(ready_o),
        .*
    );

    // One LFSR step per bit, the shifted-out bit is the random bit
    function automatic logic [63:0] randBits(input int n);
        logic [63:0] v;
        logic        b;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            b = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? lfsrTaps : 32'h0);
            v = {v[62:0], b};
        end
        return v;
    endfunction

    // Sign extend a w-bit field
    function automatic logic [63:0] sextField(input logic [63:0] v, input int w);
        logic [63:0] m;
        m = 64'd1 << (w - 1);
        return (v ^ m) - m;
    endfunction

    task automatic driveRandom();
        logic [3:0] pick;
        pick = 4'(randBits(4));
        case (pick)
            4'd0: opCode_i = exPkg::opOpImm;
            4'd1: opCode_i = exPkg::opOp;
            4'd2: opCode_i = exPkg::opOpImm32;
            4'd3: opCode_i = exPkg::opOp32;
            4'd4: opCode_i = exPkg::opLui;
            4'd5: opCode_i = exPkg::opAuipc;
            4'd6: opCode_i = exPkg::opJal;
            4'd7: opCode_i = exPkg::opJalr;
            4'd8: opCode_i = exPkg::opBranch;
            4'd9: opCode_i = exPkg::opLoad;
            4'd10: opCode_i = exPkg::opStore;
            4'd11: opCode_i = exPkg::opOp;
            4'd12: opCode_i = exPkg::opOpImm;
            4'd13: opCode_i = exPkg::opBranch;
            default: opCode_i = 7'(randBits(7));
        endcase
        funct3_i = 3'(randBits(3));
        // Mostly legal funct7, now and then junk
        pick = 4'(randBits(2));
        if (pick < 4'd2) funct7_i = exPkg::f7Base;
        else if (pick == 4'd2) funct7_i = exPkg::f7Alt;
        else funct7_i = 7'(randBits(7));
        shamt_i = 6'(randBits(6));
        rs1ReadData_i = randBits(64);
        // Equal operands now and then for BEQ and SLT edges
        rs2ReadData_i = (randBits(3) == 64'd0) ? rs1ReadData_i : randBits(64);
        case (opCode_i)
            exPkg::opLui, exPkg::opAuipc: imm_i = sextField(randBits(20), 20);
            exPkg::opJal: imm_i = sextField(randBits(20) << 1, 21);
            exPkg::opBranch: imm_i = sextField(randBits(12) << 1, 13);
            exPkg::opOpImm, exPkg::opOpImm32, exPkg::opJalr, exPkg::opLoad, exPkg::opStore:
                imm_i = sextField(randBits(12), 12);
            default: imm_i = randBits(64);
        endcase
        instAddr_i = 32'(randBits(30) << 2);
        rdWriteEnable_i = randBits(1) != 64'd0;
        rdAddr_i = 5'(randBits(5));
        way0PId_i = 2'(randBits(2));
        valid_i = randBits(3) != 64'd0;
        ready_i = randBits(2) != 64'd0;
    endtask

    initial begin
        lfsr = 32'd24;
        captures = 0;
        cycles = 0;
        timeouts = 0;
        rstN_i = 1'b0;
        rdWriteEnable_i = 1'b0;
        rdAddr_i = '0;
        instAddr_i = '0;
        rs1ReadData_i = '0;
        rs2ReadData_i = '0;
        imm_i = '0;
        opCode_i = '0;
        funct3_i = '0;
        funct7_i = '0;
        shamt_i = '0;
        valid_i = 1'b0;
        ready_i = 1'b0;
        way0PId_i = '0;
        repeat (3) @(posedge clk);
        #0.5;
        rstN_i = 1'b1;
        // Random traffic, stalls included
        while (captures < numCaptures && cycles < runLimit) begin
            driveRandom();
            if (ready_i) captures++;
            cycles++;
            @(posedge clk);
            #0.5;
        end
        if (captures < numCaptures) begin
            $display("Timeout: only %0d of %0d instructions captured in %0d cycles",
                     captures, numCaptures, runLimit);
            timeouts++;
        end
        // Stall the stage while the last result is compared
        ready_i = 1'b0;
        valid_i = 1'b0;
        cycles = 0;
        while (u_chk.cmpCount < u_chk.capCount && cycles < drainLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (u_chk.cmpCount < u_chk.capCount) begin
            $display("Timeout: checker still had %0d results left to compare",
                     u_chk.capCount - u_chk.cmpCount);
            timeouts++;
        end
        $display("Checks %0d, mismatches %0d, timeouts %0d",
                 u_chk.checkCount, u_chk.errorCount, timeouts);
        if (u_chk.errorCount == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
